// ==== build.f ====
+incdir+common
+incdir+dv
common/rv_pkg.sv
design/rv_fetch.sv
decode/rv_decode.sv
design/rv_regfile.sv
execute/rv_execute.sv
design/rv_core.sv
dv/tb_rv_core.sv

// ==== common/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ----------------------------------------
// Machine widths
// ----------------------------------------

// Data word and address width
`define RV_XLEN 32

// Integer register count, x0 included
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// ----------------------------------------
// Major opcodes, instr[6:0]
// ----------------------------------------

`define RV_OP_LUI    7'b0110111
`define RV_OP_JAL    7'b1101111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_OPIMM  7'b0010011
`define RV_OP_OP     7'b0110011

// ----------------------------------------
// Special words
// ----------------------------------------

// Full EBREAK encoding, matched as a whole word
`define RV_EBREAK 32'h0010_0073

`endif

// ==== common/rv_pkg.sv ====
`default_nettype none

`include "rv_consts.svh"

package rv_pkg;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  typedef logic [`RV_XLEN-1:0]          word_t;
  typedef logic [31:0]                  instr_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  // ----------------------------------------
  // Control encodings
  // ----------------------------------------

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // First ALU operand; zero serves LUI
  typedef enum logic [1:0] {A_RS1, A_ZERO, A_PC} alu_a_e;

  typedef enum logic {B_RS2, B_IMM} alu_b_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} res_src_e;

  // Values follow the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef struct packed {
    logic     reg_write;
    logic     mem_write;
    logic     is_branch;
    logic     is_jump;
    logic     is_ebreak;
    alu_op_e  alu_op;
    alu_a_e   alu_a;
    alu_b_e   alu_b;
    res_src_e res_src;
    br_cond_e br_cond;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
  } decoded_t;

endpackage

`default_nettype wire

// ==== decode/rv_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_decode (
  input  rv_pkg::instr_t   instr,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm;
  ctrl_t      ctrl;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // ----------------------------------------
  // Immediate formats
  // ----------------------------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      `RV_OP_LUI:    imm = imm_u;
      `RV_OP_JAL:    imm = imm_j;
      `RV_OP_BRANCH: imm = imm_b;
      `RV_OP_STORE:  imm = imm_s;
      default:       imm = imm_i;
    endcase
  end

  // ----------------------------------------
  // Control word
  // ----------------------------------------

  // Shared by register and immediate forms; alt picks SUB or SRA
  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Anything not matched below stays a NOP
  always_comb begin
    ctrl = '0;
    ctrl.alu_op  = ALU_ADD;
    ctrl.alu_a   = A_RS1;
    ctrl.alu_b   = B_RS2;
    ctrl.res_src = RES_ALU;
    ctrl.br_cond = BR_EQ;
    case (opcode)
      `RV_OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a     = A_ZERO;
        ctrl.alu_b     = B_IMM;
      end
      `RV_OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_src   = RES_PC4;
      end
      `RV_OP_BRANCH: begin
        // funct3 010 and 011 are reserved
        if (funct3[2:1] != 2'b01) begin
          ctrl.is_branch = 1'b1;
          ctrl.br_cond   = br_cond_e'(funct3);
        end
      end
      `RV_OP_LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_b     = B_IMM;
          ctrl.res_src   = RES_MEM;
        end
      end
      `RV_OP_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl.mem_write = 1'b1;
          ctrl.alu_b     = B_IMM;
        end
      end
      `RV_OP_OPIMM: begin
        // Shift immediates carry a funct7 that must be legal
        if ((funct3 != 3'b001 || f7_zero) && (funct3 != 3'b101 || f7_zero || f7_alt)) begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_b     = B_IMM;
          ctrl.alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && f7_alt);
        end
      end
      `RV_OP_OP: begin
        if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_op    = alu_from_funct(funct3, f7_alt);
        end
      end
      default: ;
    endcase
    ctrl.is_ebreak = (instr == `RV_EBREAK);
  end

  assign dec.ctrl = ctrl;
  assign dec.rs1  = instr[19:15];
  assign dec.rs2  = instr[24:20];
  assign dec.rd   = instr[11:7];
  assign dec.imm  = imm;

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core (
  input  logic           clk,
  input  logic           arst_n,

  // Instruction port, combinational read
  output rv_pkg::word_t  imem_addr,
  input  rv_pkg::instr_t imem_rdata,

  // Data port, combinational read and clocked write
  output rv_pkg::word_t  dmem_addr,
  output rv_pkg::word_t  dmem_wdata,
  output logic           dmem_we,
  input  rv_pkg::word_t  dmem_rdata,

  output logic           ebreak
);
  import rv_pkg::*;

  word_t    pc;
  word_t    pc_plus4;
  word_t    target;
  logic     pc_sel;
  decoded_t dec;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     rd_we;
  word_t    rd_data;

  assign imem_addr = pc;

  // Halt level, quiet while reset is applied
  assign ebreak = arst_n & dec.ctrl.is_ebreak;

  // ----------------------------------------
  // Fetch and decode
  // ----------------------------------------

  rv_fetch u_fetch (
    .clk      (clk),
    .arst_n   (arst_n),
    .pc_sel   (pc_sel),
    .halt     (dec.ctrl.is_ebreak),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  rv_decode u_decode (
    .instr (imem_rdata),
    .dec   (dec)
  );

  // ----------------------------------------
  // Operands and execute
  // ----------------------------------------

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .rd_we    (rd_we),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute u_execute (
    .arst_n     (arst_n),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .pc         (pc),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .pc_sel     (pc_sel),
    .rd_we      (rd_we),
    .dmem_we    (dmem_we),
    .target     (target),
    .rd_data    (rd_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata)
  );

endmodule

`default_nettype wire

// ==== design/rv_fetch.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_fetch (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          pc_sel,
  input  logic          halt,
  input  rv_pkg::word_t target,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  word_t next_pc;

  // Sequential address, also the link value for JAL
  assign pc_plus4 = pc + word_t'(4);

  // Taken branch or jump wins, halt freezes the PC
  always_comb begin
    if (pc_sel) begin
      next_pc = target;
    end else if (halt) begin
      next_pc = pc;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module rv_regfile (
  input  logic              clk,
  input  logic              arst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  logic              rd_we,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [`RV_NREGS];

  // Single write port; x0 is never written so it keeps its reset zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // Asynchronous read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// ==== dv/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// ----------------------------------------
// Instruction encoders
// ----------------------------------------

function automatic instr_t enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                 input int rd, input int rs1, input int rs2);
  return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RV_OP_OP};
endfunction

function automatic instr_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                 input int rd, input int rs1, input logic [11:0] imm);
  return {imm, 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic instr_t enc_s(input int rs2, input int rs1, input logic [11:0] imm);
  return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], `RV_OP_STORE};
endfunction

function automatic instr_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                 input int off);
  logic [12:0] i;
  i = 13'(off);
  return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], `RV_OP_BRANCH};
endfunction

function automatic instr_t enc_j(input int rd, input int off);
  logic [20:0] i;
  i = 21'(off);
  return {i[20], i[10:1], i[11], i[19:12], 5'(rd), `RV_OP_JAL};
endfunction

function automatic void emit(input instr_t w);
  prog[p] = w;
  p++;
endfunction

// LUI plus ADDI with the upper part rounded for the signed low half
function automatic void load_const(input int rd, input logic [31:0] v);
  logic [31:0] up;
  up = (v + 32'h0000_0800) >> 12;
  emit({up[19:0], 5'(rd), `RV_OP_LUI});
  emit(enc_i(`RV_OP_OPIMM, 3'd0, rd, rd, v[11:0]));
endfunction

// Result always lands in x3 and then goes to memory
function automatic void store_result(input instr_t w, input int addr);
  emit(w);
  emit(enc_s(3, 0, 12'(addr)));
endfunction

// ----------------------------------------
// Test programs
// ----------------------------------------

function automatic void build_program(input int t);
  logic [31:0] r;
  for (int k = 0; k < MEM_WORDS; k++) begin
    prog[k] = `RV_EBREAK;
  end
  p = 0;
  case (t)
    1: begin
      load_const(1, lcg_next());
      load_const(2, lcg_next());
      store_result(enc_r(3'd0, 7'h00, 3, 1, 2), 0);
      store_result(enc_r(3'd0, 7'h20, 3, 1, 2), 4);
      store_result(enc_r(3'd7, 7'h00, 3, 1, 2), 8);
      store_result(enc_r(3'd6, 7'h00, 3, 1, 2), 12);
      store_result(enc_r(3'd4, 7'h00, 3, 1, 2), 16);
      r = lcg_next();
      store_result(enc_i(`RV_OP_OPIMM, 3'd0, 3, 1, r[11:0]), 20);
      store_result(enc_i(`RV_OP_OPIMM, 3'd4, 3, 1, r[23:12]), 24);
      r = lcg_next();
      store_result(enc_i(`RV_OP_OPIMM, 3'd6, 3, 1, r[11:0]), 28);
      store_result(enc_i(`RV_OP_OPIMM, 3'd7, 3, 1, r[23:12]), 32);
    end
    2: begin
      load_const(1, lcg_next());
      load_const(2, lcg_next());
      store_result(enc_r(3'd1, 7'h00, 3, 1, 2), 0);
      store_result(enc_r(3'd5, 7'h00, 3, 1, 2), 4);
      store_result(enc_r(3'd5, 7'h20, 3, 1, 2), 8);
      r = lcg_next();
      store_result(enc_i(`RV_OP_OPIMM, 3'd1, 3, 1, {7'h00, r[4:0]}), 12);
      store_result(enc_i(`RV_OP_OPIMM, 3'd5, 3, 1, {7'h00, r[9:5]}), 16);
      store_result(enc_i(`RV_OP_OPIMM, 3'd5, 3, 1, {7'h20, r[14:10]}), 20);
      // Signed and unsigned boundaries
      load_const(5, 32'h8000_0000);
      load_const(6, 32'h7FFF_FFFF);
      store_result(enc_r(3'd2, 7'h00, 3, 5, 6), 24);
      store_result(enc_r(3'd2, 7'h00, 3, 6, 5), 28);
      store_result(enc_r(3'd3, 7'h00, 3, 5, 6), 32);
      store_result(enc_r(3'd3, 7'h00, 3, 0, 5), 36);
      store_result(enc_r(3'd2, 7'h00, 3, 5, 0), 40);
      store_result(enc_i(`RV_OP_OPIMM, 3'd3, 3, 6, 12'hFFF), 44);
    end
    3: begin
      load_const(1, lcg_next());
      load_const(2, lcg_next());
      load_const(3, lcg_next());
      emit(enc_s(1, 0, 12'd128));
      emit(enc_s(2, 0, 12'd132));
      emit(enc_s(3, 0, 12'd200));
      emit(enc_i(`RV_OP_LOAD, 3'd2, 4, 0, 12'd128));
      emit(enc_i(`RV_OP_LOAD, 3'd2, 5, 0, 12'd132));
      emit(enc_i(`RV_OP_LOAD, 3'd2, 6, 0, 12'd200));
      emit(enc_s(4, 0, 12'd64));
      emit(enc_s(5, 0, 12'd68));
      emit(enc_s(6, 0, 12'd72));
    end
    4: begin
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 2, 0, 12'd1));
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 3, 0, 12'd11));
      // Sum 1..10 into x1
      emit(enc_r(3'd0, 7'h00, 1, 1, 2));
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 2, 2, 12'd1));
      emit(enc_b(3'd1, 2, 3, -8));
      emit(enc_s(1, 0, 12'd0));
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 5, 0, 12'd5));
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 4, 4, 12'd1));
      emit(enc_b(3'd4, 4, 5, -4));
      emit(enc_s(4, 0, 12'd4));
      emit(enc_b(3'd7, 2, 3, 8));
      emit(enc_s(3, 0, 12'd8));
      emit(enc_b(3'd6, 3, 2, 8));
      emit(enc_s(3, 0, 12'd12));
      emit(enc_j(6, 8));
      emit(enc_s(3, 0, 12'd16));
      emit(enc_s(6, 0, 12'd20));
    end
    default: begin
      // First word is a store that is decoded while reset is held
      emit(enc_s(0, 0, 12'd8));
      load_const(1, lcg_next());
      emit(enc_i(`RV_OP_OPIMM, 3'd0, 0, 0, 12'd123));
      emit({20'h12345, 5'd0, `RV_OP_LUI});
      emit(enc_r(3'd0, 7'h00, 0, 1, 1));
      emit(enc_s(0, 0, 12'd0));
      emit(enc_s(0, 0, 12'd4));
    end
  endcase
endfunction

`endif

// ==== dv/tb_rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rv_consts.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int NTESTS    = 5;
  localparam int MEM_WORDS = 64;
  localparam int HALT_HOLD = 5;

  logic   clk;
  logic   arst_n;
  word_t  imem_addr;
  instr_t imem_rdata;
  word_t  dmem_addr;
  word_t  dmem_wdata;
  word_t  dmem_rdata;
  logic   dmem_we;
  logic   ebreak;

  instr_t      prog [MEM_WORDS];
  word_t       dmem [MEM_WORDS];
  word_t       ref_mem [MEM_WORDS];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  int          ref_count;
  word_t       ref_pc;
  int          p;
  logic [31:0] lcg_state;

  int   cyc;
  int   st_idx;
  int   post_cnt;
  logic halted;
  logic done;
  int   err_count;
  int   total_cyc;
  int   cyc_limit;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Initial data pattern unique per word address
  function automatic word_t mem_fill(input int i);
    return 32'hC3A5_0000 ^ (32'(i) * 32'h0101_0101) ^ 32'(i << 2);
  endfunction

  `include "tb_programs.svh"

  rv_core UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .ebreak     (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------
  // Memories
  // ----------------------------------------

  assign imem_rdata = prog[imem_addr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  always @(posedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= mem_fill(i);
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic void ref_run();
    word_t       x [32];
    word_t       pc;
    word_t       next_pc;
    word_t       a;
    word_t       b;
    word_t       res;
    word_t       addr;
    instr_t      w;
    logic [6:0]  op;
    logic [2:0]  f3;
    int          rd;
    int          rs1;
    int          rs2;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_j;
    logic        take;
    exp_addr.delete();
    exp_data.delete();
    for (int k = 0; k < MEM_WORDS; k++) begin
      ref_mem[k] = mem_fill(k);
    end
    for (int k = 0; k < 32; k++) begin
      x[k] = '0;
    end
    pc = `RV_RESET_PC;
    ref_count = 0;
    while (ref_count < 1000) begin
      w = prog[pc[7:2]];
      ref_count++;
      if (w == `RV_EBREAK) break;
      op    = w[6:0];
      f3    = w[14:12];
      rd    = int'(w[11:7]);
      rs1   = int'(w[19:15]);
      rs2   = int'(w[24:20]);
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      next_pc = pc + 32'd4;
      case (op)
        `RV_OP_LUI: x[rd] = {w[31:12], 12'h000};
        `RV_OP_JAL: begin
          x[rd]   = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        `RV_OP_BRANCH: begin
          case (f3)
            3'd0:    take = (x[rs1] == x[rs2]);
            3'd1:    take = (x[rs1] != x[rs2]);
            3'd4:    take = ($signed(x[rs1]) < $signed(x[rs2]));
            3'd5:    take = ($signed(x[rs1]) >= $signed(x[rs2]));
            3'd6:    take = (x[rs1] < x[rs2]);
            3'd7:    take = (x[rs1] >= x[rs2]);
            default: take = 1'b0;
          endcase
          if (take) next_pc = pc + imm_b;
        end
        `RV_OP_LOAD: begin
          addr = x[rs1] + imm_i;
          if (f3 == 3'd2) x[rd] = ref_mem[addr[7:2]];
        end
        `RV_OP_STORE: begin
          addr = x[rs1] + imm_s;
          if (f3 == 3'd2) begin
            exp_addr.push_back(addr);
            exp_data.push_back(x[rs2]);
            ref_mem[addr[7:2]] = x[rs2];
          end
        end
        `RV_OP_OPIMM, `RV_OP_OP: begin
          a = x[rs1];
          b = (op == `RV_OP_OP) ? x[rs2] : imm_i;
          case (f3)
            3'd0:    res = (op == `RV_OP_OP && w[30]) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd3:    res = {31'b0, a < b};
            3'd4:    res = a ^ b;
            3'd5:    res = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    res = a | b;
            default: res = a & b;
          endcase
          x[rd] = res;
        end
        default: ;
      endcase
      x[0] = '0;
      pc = next_pc;
    end
    // Address of the halting EBREAK
    ref_pc = pc;
  endfunction

  // ----------------------------------------
  // Compare process
  // ----------------------------------------

  always @(posedge clk) begin
    if (!arst_n) begin
      if (dmem_we || ebreak) begin
        $display("dmem_we or ebreak went high during reset at %0t ns", $time);
        err_count++;
      end
      cyc      = 0;
      st_idx   = 0;
      post_cnt = 0;
      halted   = 1'b0;
      done     = 1'b0;
    end else if (!done) begin
      cyc++;
      if (dmem_we) begin
        if (halted) begin
          $display("A store happened after the core halted, at %0t ns", $time);
          err_count++;
        end else if (st_idx >= exp_addr.size()) begin
          $display("Unexpected extra store to %h at %0t ns", dmem_addr, $time);
          err_count++;
        end else begin
          if (dmem_addr !== exp_addr[st_idx] || dmem_wdata !== exp_data[st_idx]) begin
            $display("Error at %0t ns: store addr %h data %h, expected addr %h data %h",
                     $time, dmem_addr, dmem_wdata, exp_addr[st_idx], exp_data[st_idx]);
            err_count++;
          end
          st_idx++;
        end
      end
      if (halted) begin
        if (!ebreak) begin
          $display("ebreak dropped while the core should stay halted, at %0t ns", $time);
          err_count++;
        end
        post_cnt++;
        if (post_cnt == HALT_HOLD) done = 1'b1;
      end else if (ebreak) begin
        halted = 1'b1;
        if (cyc != ref_count) begin
          $display("Error at %0t ns: ebreak after %0d cycles, expected %0d",
                   $time, cyc, ref_count);
          err_count++;
        end
        if (imem_addr !== ref_pc) begin
          $display("Error at %0t ns: halted at pc %h, expected %h",
                   $time, imem_addr, ref_pc);
          err_count++;
        end
        if (st_idx != exp_addr.size()) begin
          $display("Only %0d of %0d expected stores were seen", st_idx, exp_addr.size());
          err_count++;
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
          if (dmem[k] !== ref_mem[k]) begin
            $display("Error at %0t ns: data word %0d is %h, expected %h",
                     $time, k, dmem[k], ref_mem[k]);
            err_count++;
          end
        end
      end
    end
  end

  // Watchdog over the whole run
  always @(posedge clk) begin
    total_cyc++;
    if (cyc_limit > 0 && total_cyc > cyc_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cyc_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    int errs_before;
    int failed;
    arst_n    = 1'b0;
    err_count = 0;
    total_cyc = 0;
    cyc_limit = 0;
    failed    = 0;
    p         = 0;
    // Dry pass sizes the watchdog before the same random stream is replayed
    lcg_state = 32'd86;
    for (int t = 1; t <= NTESTS; t++) begin
      build_program(t);
      ref_run();
      cyc_limit += ref_count + 20;
    end
    lcg_state = 32'd86;
    for (int t = 1; t <= NTESTS; t++) begin
      errs_before = err_count;
      @(posedge clk);
      arst_n <= 1'b0;
      // Halt word at the reset PC while reset is held
      prog[0] = `RV_EBREAK;
      repeat (2) @(posedge clk);
      build_program(t);
      ref_run();
      @(posedge clk);
      arst_n <= 1'b1;
      do begin
        @(posedge clk);
      end while (!done);
      if (err_count == errs_before) begin
        $display("test %0d: passed, %0d instructions", t, ref_count);
      end else begin
        $display("test %0d: failed with %0d errors", t, err_count - errs_before);
        failed++;
      end
    end
    $display("tests run %0d, failed %0d, errors %0d", NTESTS, failed, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== execute/rv_execute.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_execute (
  input  logic             arst_n,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    pc_plus4,
  input  rv_pkg::word_t    dmem_rdata,
  output logic             pc_sel,
  output logic             rd_we,
  output logic             dmem_we,
  output rv_pkg::word_t    target,
  output rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata
);
  import rv_pkg::*;

  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_res;
  logic [4:0] shamt;
  logic       rs_eq;
  logic       rs_lt;
  logic       rs_ltu;
  logic       br_taken;

  // ----------------------------------------
  // Operands and ALU
  // ----------------------------------------

  always_comb begin
    case (dec.ctrl.alu_a)
      A_ZERO:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = (dec.ctrl.alu_b == B_IMM) ? dec.imm : rs2_data;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (dec.ctrl.alu_op)
      ALU_SUB:  alu_res = alu_a - alu_b;
      ALU_AND:  alu_res = alu_a & alu_b;
      ALU_OR:   alu_res = alu_a | alu_b;
      ALU_XOR:  alu_res = alu_a ^ alu_b;
      ALU_SLT:  alu_res = word_t'($signed(alu_a) < $signed(alu_b));
      ALU_SLTU: alu_res = word_t'(alu_a < alu_b);
      ALU_SLL:  alu_res = alu_a << shamt;
      ALU_SRL:  alu_res = alu_a >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(alu_a) >>> shamt);
      default:  alu_res = alu_a + alu_b;
    endcase
  end

  // ----------------------------------------
  // Branch and jump
  // ----------------------------------------

  assign rs_eq  = (rs1_data == rs2_data);
  assign rs_lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign rs_ltu = (rs1_data < rs2_data);

  always_comb begin
    case (dec.ctrl.br_cond)
      BR_EQ:   br_taken = rs_eq;
      BR_NE:   br_taken = !rs_eq;
      BR_LT:   br_taken = rs_lt;
      BR_GE:   br_taken = !rs_lt;
      BR_LTU:  br_taken = rs_ltu;
      BR_GEU:  br_taken = !rs_ltu;
      default: br_taken = 1'b0;
    endcase
  end

  // Same PC-relative adder for JAL and all branches
  assign target = pc + dec.imm;
  assign pc_sel = dec.ctrl.is_jump | (dec.ctrl.is_branch & br_taken);

  // ----------------------------------------
  // Memory and write-back
  // ----------------------------------------

  assign dmem_addr  = alu_res;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = arst_n & dec.ctrl.mem_write;

  always_comb begin
    case (dec.ctrl.res_src)
      RES_MEM: rd_data = dmem_rdata;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_res;
    endcase
  end

  assign rd_we = arst_n & dec.ctrl.reg_write;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

verilator --binary --timing -f build.f --top-module tb_rv_core -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
